// ==== build.f ====
logic/hps_link_pkg.sv
logic/cmd_fetch.sv
logic/cmd_queue.sv
logic/cmd_exec.sv
logic/hps_link_top.sv
verif/hps_link_tb.sv

// ==== logic/cmd_exec.sv ====
// Command execute: applies commands to LEDs and display, writes one response word each
`timescale 1ns/1ps

module cmd_exec (
	input  logic                      CLOCK_50,
	input  logic                      arst_n,
	// Receiver side, from the queue
	input  logic                      qe_req,
	output logic                      qe_ack,
	input  hps_link_pkg::cmd_word_t   qe_cmd,
	// Outgoing FIFO
	output logic [31:0]               out_data,
	output logic                      out_write,
	input  logic                      out_full,
	// Board outputs
	output logic [9:0]                leds,
	output hps_link_pkg::seg_bank_t   hex
);

	import hps_link_pkg::*;

	logic [HEX_W-1:0]  hex_value;
	logic [SEQ_W-1:0]  seq;
	logic [LED_W-1:0]  leds_next;
	logic [HEX_W-1:0]  hex_next;
	logic              fire;
	rsp_word_t         rsp;

	// ==================================================
	// Command decode
	// ==================================================
	// New request, not yet acked, room downstream
	assign fire = qe_req && !qe_ack && !out_full;

	// Next state for the current head command
	always_comb begin
		leds_next = leds;
		hex_next  = hex_value;
		case (cmd_op_e'(qe_cmd.op))
			OP_SET_LED: begin
				leds_next = qe_cmd.x_value[LED_W-1:0];
			end
			OP_INVERT_LED: begin
				leds_next = ~leds;
			end
			OP_SET_HEX: begin
				// Upper half from y, lower half from x
				hex_next = {qe_cmd.y_value[HEX_W/2-1:0], qe_cmd.x_value[HEX_W/2-1:0]};
			end
			default: begin
				// NOP and unknown opcodes
				leds_next = leds;
			end
		endcase
	end

	// ==================================================
	// Response word
	// ==================================================
	// LED state after the command, seq before the increment
	always_comb begin
		rsp      = '0;
		rsp.leds = leds_next;
		rsp.seq  = seq;
		rsp.op   = qe_cmd.op;
	end

	assign out_data  = rsp;
	assign out_write = fire;

	// ==================================================
	// State update and ack
	// ==================================================
	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			leds      <= '0;
			hex_value <= '0;
			seq       <= '0;
			qe_ack    <= 1'b0;
		end else begin
			if (fire) begin
				leds      <= leds_next;
				hex_value <= hex_next;
				// Wraps at 256
				seq       <= seq + 1'b1;
				qe_ack    <= 1'b1;
			end else if (qe_ack && !qe_req) begin
				// Queue dropped req, finish the handshake
				qe_ack <= 1'b0;
			end
		end
	end

	// Seven-segment decode, one nibble per digit
	always_comb begin
		for (int i = 0; i < HEX_DIGITS; i++) begin
			hex[i] = seg7(hex_value[i*4 +: 4]);
		end
	end

	// ==================================================
	// Checks
	// ==================================================
	// Stalled command gets no write and stays at the queue head
	a_write_not_full: assert property (
		@(posedge CLOCK_50) disable iff (!arst_n)
		qe_req && !qe_ack && out_full |-> !out_write ##1 (qe_req && $stable(qe_cmd))
	) else $error("response written while full or stalled command changed");

endmodule

// ==== logic/cmd_fetch.sv ====
// Command fetch: pops host words from the incoming FIFO and offers them over four-phase req/ack
`timescale 1ns/1ps

module cmd_fetch (
	input  logic                      CLOCK_50,
	input  logic                      arst_n,
	// Incoming FIFO, show-ahead
	input  logic [31:0]               in_data,
	input  logic                      in_empty,
	output logic                      in_read,
	// Sender side of the fetch to queue link
	output logic                      fq_req,
	input  logic                      fq_ack,
	output hps_link_pkg::cmd_word_t   fq_cmd
);

	import hps_link_pkg::*;

	// ==================================================
	// Link state
	// ==================================================
	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_OFFER,
		FETCH_RELEASE
	} fetch_state_e;

	fetch_state_e state;

	// Head word valid while not empty
	// Pop only from idle, so at most one command held here
	assign in_read = (state == FETCH_IDLE) && !in_empty;

	// Req follows the offer state, one cycle after the pop
	assign fq_req = (state == FETCH_OFFER);

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			state <= FETCH_IDLE;
		end else begin
			case (state)
				FETCH_IDLE: begin
					// Pop and capture on the same edge
					if (in_read) begin
						state <= FETCH_OFFER;
					end
				end
				FETCH_OFFER: begin
					// Hold req and data until the queue takes it
					if (fq_ack) begin
						state <= FETCH_RELEASE;
					end
				end
				FETCH_RELEASE: begin
					// Req already low, wait for ack to drop
					if (!fq_ack) begin
						state <= FETCH_IDLE;
					end
				end
				default: begin
					state <= FETCH_IDLE;
				end
			endcase
		end
	end

	// ==================================================
	// Command capture
	// ==================================================
	// Payload only, stable from pop through release
	always_ff @(posedge CLOCK_50) begin
		if (in_read) begin
			fq_cmd <= cmd_word_t'(in_data);
		end
	end

	// ==================================================
	// Checks
	// ==================================================
	// Once raised, req stays up until the queue acknowledges
	a_req_held: assert property (
		@(posedge CLOCK_50) disable iff (!arst_n)
		fq_req && !fq_ack |=> fq_req
	) else $error("fq_req dropped before fq_ack");

	// A new offer only after the previous ack has gone low
	a_req_after_ack_low: assert property (
		@(posedge CLOCK_50) disable iff (!arst_n)
		$rose(fq_req) |-> !$past(fq_ack)
	) else $error("fq_req raised while fq_ack still high");

endmodule

// ==== logic/cmd_queue.sv ====
// Command queue: small circular buffer between the fetch link and the exec link
`timescale 1ns/1ps

module cmd_queue (
	input  logic                      CLOCK_50,
	input  logic                      arst_n,
	// Receiver side, from fetch
	input  logic                      fq_req,
	output logic                      fq_ack,
	input  hps_link_pkg::cmd_word_t   fq_cmd,
	// Sender side, toward exec
	output logic                      qe_req,
	input  logic                      qe_ack,
	output hps_link_pkg::cmd_word_t   qe_cmd
);

	import hps_link_pkg::*;

	cmd_word_t          mem [CMD_DEPTH];
	logic [QPTR_W-1:0]  wr_ptr;
	logic [QPTR_W-1:0]  rd_ptr;
	logic [QCNT_W-1:0]  count;
	logic               full;
	logic               do_write;
	logic               do_pop;

	assign full = (count == QCNT_W'(CMD_DEPTH));

	// Accept a fresh req only with room left
	assign do_write = fq_req && !fq_ack && !full;

	// Exec has taken the head
	assign do_pop = qe_req && qe_ack;

	// Head entry stays put while req is up
	assign qe_cmd = mem[rd_ptr];

	// ==================================================
	// Storage
	// ==================================================
	always_ff @(posedge CLOCK_50) begin
		if (do_write) begin
			mem[wr_ptr] <= fq_cmd;
		end
	end

	// ==================================================
	// Pointers, count and both handshakes
	// ==================================================
	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			fq_ack <= 1'b0;
			qe_req <= 1'b0;
		end else begin
			// Input link, ack one cycle after req seen
			if (do_write) begin
				fq_ack <= 1'b1;
				if (wr_ptr == QPTR_W'(CMD_DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end else if (fq_ack && !fq_req) begin
				fq_ack <= 1'b0;
			end

			// Output link
			if (do_pop) begin
				qe_req <= 1'b0;
				if (rd_ptr == QPTR_W'(CMD_DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end else if (!qe_req && !qe_ack && (count != '0)) begin
				// Link idle and something waiting
				qe_req <= 1'b1;
			end

			// Occupancy
			if (do_write && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_write)
				count <= count - 1'b1;
		end
	end

	// ==================================================
	// Checks
	// ==================================================
	// A write never lands on an unread entry
	a_no_write_full: assert property (
		@(posedge CLOCK_50) disable iff (!arst_n)
		do_write |-> (wr_ptr != rd_ptr) || (count == '0)
	) else $error("command written into a full queue");

	// Exec never completes a transfer on an empty queue
	a_no_pop_empty: assert property (
		@(posedge CLOCK_50) disable iff (!arst_n)
		do_pop |-> (count != '0)
	) else $error("command popped from an empty queue");

endmodule

// ==== logic/hps_link_pkg.sv ====
// HPS link shared widths, opcode encoding, command and response words, segment decode
package hps_link_pkg;

	// ==================================================
	// Widths and sizes
	// ==================================================
	localparam int WORD_W     = 32;
	localparam int ARG_W      = 14;
	localparam int OP_W       = 4;
	localparam int LED_W      = 10;
	localparam int HEX_DIGITS = 6;
	localparam int SEG_W      = 7;
	localparam int CMD_DEPTH  = 4;
	localparam int SEQ_W      = 8;

	// Derived sizes
	localparam int HEX_W     = HEX_DIGITS * 4;
	localparam int QPTR_W    = $clog2(CMD_DEPTH);
	localparam int QCNT_W    = $clog2(CMD_DEPTH + 1);
	localparam int RSP_PAD_W = WORD_W - LED_W - SEQ_W - OP_W;

	// ==================================================
	// Types
	// ==================================================
	// Known opcodes, all others ignored by exec
	typedef enum logic [OP_W-1:0] {
		OP_NOP        = 4'd0,
		OP_SET_LED    = 4'd1,
		OP_INVERT_LED = 4'd2,
		OP_SET_HEX    = 4'd3
	} cmd_op_e;

	// Host command word, op in the low nibble
	typedef struct packed {
		logic [ARG_W-1:0] y_value;
		logic [ARG_W-1:0] x_value;
		logic [OP_W-1:0]  op;
	} cmd_word_t;

	// One response per executed command
	typedef struct packed {
		logic [RSP_PAD_W-1:0] pad;
		logic [LED_W-1:0]     leds;
		logic [SEQ_W-1:0]     seq;
		logic [OP_W-1:0]      op;
	} rsp_word_t;

	// Digit 0 is the rightmost, lowest nibble
	typedef logic [HEX_DIGITS-1:0][SEG_W-1:0] seg_bank_t;

	// Active-low segments, bit order gfedcba
	function automatic logic [SEG_W-1:0] seg7(input logic [3:0] nibble);
		case (nibble)
			4'h0: seg7 = 7'b1000000;
			4'h1: seg7 = 7'b1111001;
			4'h2: seg7 = 7'b0100100;
			4'h3: seg7 = 7'b0110000;
			4'h4: seg7 = 7'b0011001;
			4'h5: seg7 = 7'b0010010;
			4'h6: seg7 = 7'b0000010;
			4'h7: seg7 = 7'b1111000;
			4'h8: seg7 = 7'b0000000;
			4'h9: seg7 = 7'b0010000;
			4'hA: seg7 = 7'b0001000;
			4'hB: seg7 = 7'b0000011;
			4'hC: seg7 = 7'b1000110;
			4'hD: seg7 = 7'b0100001;
			4'hE: seg7 = 7'b0000110;
			default: seg7 = 7'b0001110;
		endcase
	endfunction

endpackage

// ==== logic/hps_link_top.sv ====
// HPS command link top level: fetch, queue and exec between the two host FIFOs
`timescale 1ns/1ps

module hps_link_top (
	input  logic                      CLOCK_50,
	input  logic                      arst_n,
	// Host to fabric FIFO
	input  logic [31:0]               in_data,
	input  logic                      in_empty,
	output logic                      in_read,
	// Fabric to host FIFO
	output logic [31:0]               out_data,
	output logic                      out_write,
	input  logic                      out_full,
	// Board outputs
	output logic [9:0]                leds,
	output hps_link_pkg::seg_bank_t   hex
);

	import hps_link_pkg::*;

	// ==================================================
	// Inter-stage links
	// ==================================================
	// Fetch to queue
	logic       fq_req;
	logic       fq_ack;
	cmd_word_t  fq_cmd;

	// Queue to exec
	logic       qe_req;
	logic       qe_ack;
	cmd_word_t  qe_cmd;

	// Word pop and unpack
	cmd_fetch cmd_fetch_i (
		.CLOCK_50 (CLOCK_50),
		.arst_n   (arst_n),
		.in_data  (in_data),
		.in_empty (in_empty),
		.in_read  (in_read),
		.fq_req   (fq_req),
		.fq_ack   (fq_ack),
		.fq_cmd   (fq_cmd)
	);

	// Up to CMD_DEPTH commands in flight here
	cmd_queue cmd_queue_i (
		.CLOCK_50 (CLOCK_50),
		.arst_n   (arst_n),
		.fq_req   (fq_req),
		.fq_ack   (fq_ack),
		.fq_cmd   (fq_cmd),
		.qe_req   (qe_req),
		.qe_ack   (qe_ack),
		.qe_cmd   (qe_cmd)
	);

	// LEDs, display and responses
	cmd_exec cmd_exec_i (
		.CLOCK_50  (CLOCK_50),
		.arst_n    (arst_n),
		.qe_req    (qe_req),
		.qe_ack    (qe_ack),
		.qe_cmd    (qe_cmd),
		.out_data  (out_data),
		.out_write (out_write),
		.out_full  (out_full),
		.leds      (leds),
		.hex       (hex)
	);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the HPS link testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f build.f --top-module hps_link_tb \
	-Mdir obj_dir -o hps_link_sim

./obj_dir/hps_link_sim

// ==== verif/hps_link_tb.sv ====
// HPS link testbench: host FIFO models, command table, response and display checks
`timescale 1ns/1ps

module hps_link_tb;

	import hps_link_pkg::*;

	localparam int N_ROWS    = 19;
	localparam int N_SINGLE  = 9;
	localparam int RSP_LIMIT = 200;
	localparam int BURST_LIM = 2000;

	// Active-low gfedcba glyphs, index is the nibble
	localparam logic [6:0] GLYPHS [16] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
		7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
		7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
		7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
	};

	logic         CLOCK_50;
	logic         arst_n;
	logic [31:0]  in_data;
	logic         in_empty;
	logic         in_read;
	logic [31:0]  out_data;
	logic         out_write;
	logic         out_full;
	logic [9:0]   leds;
	seg_bank_t    hex;
	logic [41:0]  hex_flat;

	// Host side FIFO contents
	logic [31:0]  in_q [$];
	logic [31:0]  rsp_q [$];

	// Values seen at the last rising edge
	logic         rd_seen;
	logic         wr_seen;
	logic         full_seen;
	logic [31:0]  wr_data;

	logic [31:0]  lcg_state;
	logic         stall_on;

	// Stimulus and expected values, one row per command
	logic [31:0]  tbl_cmd [N_ROWS];
	logic [9:0]   tbl_leds [N_ROWS];
	logic [23:0]  tbl_hex [N_ROWS];

	hps_link_top hps_link_top_i (
		.CLOCK_50  (CLOCK_50),
		.arst_n    (arst_n),
		.in_data   (in_data),
		.in_empty  (in_empty),
		.in_read   (in_read),
		.out_data  (out_data),
		.out_write (out_write),
		.out_full  (out_full),
		.leds      (leds),
		.hex       (hex)
	);

	assign hex_flat = hex;

	always #2 CLOCK_50 = ~CLOCK_50;

	always @(posedge CLOCK_50) begin
		rd_seen   <= in_read;
		wr_seen   <= out_write;
		full_seen <= out_full;
		wr_data   <= out_data;
	end

	// ==================================================
	// Helpers
	// ==================================================
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// y in the top bits, op in the low nibble
	function automatic logic [31:0] make_cmd(input logic [3:0] op, input logic [13:0] x,
			input logic [13:0] y);
		return {y, x, op};
	endfunction

	// Zero pad, LED state, seq, raw op
	function automatic logic [31:0] expect_rsp(input int row);
		return {10'd0, tbl_leds[row], 8'(row), tbl_cmd[row][3:0]};
	endfunction

	function automatic logic [41:0] expect_hex(input logic [23:0] v);
		logic [41:0] r;
		for (int i = 0; i < 6; i++) begin
			r[i*7 +: 7] = GLYPHS[v[i*4 +: 4]];
		end
		return r;
	endfunction

	task automatic check(input logic [63:0] actual, input logic [63:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("ERR %0t: %s, got %h expected %h", $time, msg, actual, expected);
			$display("SIMULATION FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic timeout(input string what, input int limit);
		$display("Timeout after %0d cycles: %s", limit, what);
		$display("SIMULATION FAILED");
		$fatal(1, "wait limit reached");
	endtask

	task automatic set_row(input int idx, input logic [3:0] op, input logic [13:0] x,
			input logic [13:0] y, input logic [9:0] l, input logic [23:0] h);
		tbl_cmd[idx]  = make_cmd(op, x, y);
		tbl_leds[idx] = l;
		tbl_hex[idx]  = h;
	endtask

	// One clock: update FIFO models, then drive inputs on the falling edge
	task automatic step();
		@(negedge CLOCK_50);
		if (arst_n) begin
			check(64'(wr_seen & full_seen), 64'd0, "out_write while out_full");
			check(64'(rd_seen && (in_q.size() == 0)), 64'd0, "in_read on empty FIFO");
			if (rd_seen)
				void'(in_q.pop_front());
			if (wr_seen)
				rsp_q.push_back(wr_data);
		end
		lcg_state = lcg_next(lcg_state);
		// Stall phases leave about one free cycle in four
		out_full = stall_on ? (lcg_state[17:16] != 2'b00) : 1'b0;
		in_empty = (in_q.size() == 0);
		in_data  = in_empty ? 32'd0 : in_q[0];
	endtask

	task automatic check_response(input int row);
		logic [31:0] got;
		got = rsp_q.pop_front();
		check(64'(got), 64'(expect_rsp(row)), $sformatf("response word, row %0d", row));
		check(64'(leds), 64'(tbl_leds[row]), $sformatf("leds, row %0d", row));
		check(64'(hex_flat), 64'(expect_hex(tbl_hex[row])), $sformatf("hex, row %0d", row));
	endtask

	task automatic wait_response();
		int n;
		n = 0;
		while (rsp_q.size() == 0) begin
			if (n == RSP_LIMIT) begin
				timeout("no response word was written", RSP_LIMIT);
			end else begin
				step();
				n++;
			end
		end
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		int next_row;
		int n;
		CLOCK_50  = 1'b0;
		arst_n    = 1'b0;
		in_data   = 32'd0;
		in_empty  = 1'b1;
		out_full  = 1'b0;
		rd_seen   = 1'b0;
		wr_seen   = 1'b0;
		full_seen = 1'b0;
		wr_data   = 32'd0;
		lcg_state = 32'd2622;
		stall_on  = 1'b0;

		// Single commands, LED then display then ignored opcodes
		set_row(0, OP_SET_LED, 14'h02A5, 14'h0000, 10'h2A5, 24'h000000);
		set_row(1, OP_SET_LED, 14'h3C3F, 14'h1111, 10'h03F, 24'h000000);
		set_row(2, OP_INVERT_LED, 14'h0000, 14'h0000, 10'h3C0, 24'h000000);
		set_row(3, OP_INVERT_LED, 14'h3FFF, 14'h3FFF, 10'h03F, 24'h000000);
		set_row(4, OP_SET_HEX, 14'h2123, 14'h1ABC, 10'h03F, 24'hABC123);
		set_row(5, OP_SET_HEX, 14'h0DEF, 14'h0F00, 10'h03F, 24'hF00DEF);
		set_row(6, OP_NOP, 14'h1234, 14'h3FFF, 10'h03F, 24'hF00DEF);
		set_row(7, 4'h7, 14'h0001, 14'h0002, 10'h03F, 24'hF00DEF);
		set_row(8, 4'hF, 14'h3FFF, 14'h3FFF, 10'h03F, 24'hF00DEF);
		// Burst of ten under back-pressure
		set_row(9, OP_SET_LED, 14'h0001, 14'h0000, 10'h001, 24'hF00DEF);
		set_row(10, OP_INVERT_LED, 14'h0000, 14'h0000, 10'h3FE, 24'hF00DEF);
		set_row(11, OP_SET_HEX, 14'h0789, 14'h0456, 10'h3FE, 24'h456789);
		set_row(12, 4'h5, 14'h0000, 14'h0000, 10'h3FE, 24'h456789);
		set_row(13, OP_SET_LED, 14'h0100, 14'h0000, 10'h100, 24'h456789);
		set_row(14, OP_INVERT_LED, 14'h0000, 14'h0000, 10'h2FF, 24'h456789);
		set_row(15, OP_NOP, 14'h0000, 14'h0000, 10'h2FF, 24'h456789);
		set_row(16, OP_SET_HEX, 14'h0000, 14'h0000, 10'h2FF, 24'h000000);
		set_row(17, OP_INVERT_LED, 14'h0000, 14'h0000, 10'h100, 24'h000000);
		set_row(18, OP_SET_LED, 14'h03FF, 14'h0000, 10'h3FF, 24'h000000);

		// Reset for 4 cycles, released on a falling edge
		for (int i = 0; i < 4; i++) begin
			step();
		end
		arst_n = 1'b1;

		// Idle after reset with nothing to read
		for (int i = 0; i < 8; i++) begin
			step();
			check(64'(rd_seen), 64'd0, "in_read after reset");
			check(64'(wr_seen), 64'd0, "out_write after reset");
			check(64'(leds), 64'd0, "leds after reset");
			check(64'(hex_flat), 64'(expect_hex(24'h000000)), "hex after reset");
		end

		// One command at a time, no stalls
		for (int r = 0; r < N_SINGLE; r++) begin
			in_q.push_back(tbl_cmd[r]);
			wait_response();
			check_response(r);
		end

		// All ten queued at once
		stall_on = 1'b1;
		for (int r = N_SINGLE; r < N_ROWS; r++) begin
			in_q.push_back(tbl_cmd[r]);
		end
		next_row = N_SINGLE;
		n = 0;
		while (next_row < N_ROWS) begin
			if (n == BURST_LIM) begin
				timeout("burst responses did not all arrive", BURST_LIM);
			end else begin
				step();
				n++;
				if (rsp_q.size() > 0) begin
					check_response(next_row);
					next_row++;
				end
			end
		end

		// Drain, nothing more may appear
		stall_on = 1'b0;
		for (int i = 0; i < 20; i++) begin
			step();
		end
		check(64'(rsp_q.size()), 64'd0, "extra response words");
		check(64'(in_q.size()), 64'd0, "commands left in incoming FIFO");
		check(64'(leds), 64'(tbl_leds[N_ROWS-1]), "final leds");

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule
